// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_axil_bridge
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: axil_port_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module axil_port_master
  import mem_bridge_pkg::*;
(
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,

  input  wire mem_msg_s                      req_i,
  input  wire logic                          req_v_i,
  output logic                               req_ready_and_o,

  output mem_msg_s                           resp_o,
  output logic                               resp_v_o,
  input  wire logic                          resp_ready_and_i,

  output logic [`AXIL_ADDR_WIDTH-1:0]        awaddr_o,
  output logic [2:0]                         awprot_o,
  output logic                               awvalid_o,
  input  wire logic                          awready_i,

  output logic [`AXIL_DATA_WIDTH-1:0]        wdata_o,
  output logic [`AXIL_DATA_WIDTH/8-1:0]      wstrb_o,
  output logic                               wvalid_o,
  input  wire logic                          wready_i,

  input  wire logic [1:0]                    bresp_i,
  input  wire logic                          bvalid_i,
  output logic                               bready_o,

  output logic [`AXIL_ADDR_WIDTH-1:0]        araddr_o,
  output logic [2:0]                         arprot_o,
  output logic                               arvalid_o,
  input  wire logic                          arready_i,

  input  wire logic [`AXIL_DATA_WIDTH-1:0]   rdata_i,
  input  wire logic [1:0]                    rresp_i,
  input  wire logic                          rvalid_i,
  output logic                               rready_o
);

  localparam int STRB_WIDTH = `AXIL_DATA_WIDTH / 8;
  localparam int LANE_WIDTH = $clog2(STRB_WIDTH);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e                       state_r;
  mem_header_s                  hdr_r;
  logic [`AXIL_DATA_WIDTH-1:0]  wdata_r;
  logic [STRB_WIDTH-1:0]        wstrb_r;
  logic [`AXIL_DATA_WIDTH-1:0]  rdata_r;
  logic [STRB_WIDTH-1:0]        strb;
  logic [LANE_WIDTH-1:0]        req_lane;
  logic [LANE_WIDTH-1:0]        hdr_lane;
  logic                         aw_done_r;
  logic                         w_done_r;
  logic                         is_write;
  logic                         accept;
  logic                         aw_fire;
  logic                         w_fire;
  logic                         ar_fire;
  logic                         b_fire;
  logic                         r_fire;

  assign req_lane = req_i.header.addr.flat[LANE_WIDTH-1:0];
  assign hdr_lane = hdr_r.addr.flat[LANE_WIDTH-1:0];
  assign is_write = (hdr_r.msg_type == MEM_WR);

  // Byte enables from size, shifted into the addressed lane
  always_comb
  begin
    case (req_i.header.size)
      SIZE_1:  strb = STRB_WIDTH'(4'h1) << req_lane;
      SIZE_2:  strb = STRB_WIDTH'(4'h3) << req_lane;
      default: strb = STRB_WIDTH'(4'hf) << req_lane;
    endcase
  end

  assign req_ready_and_o = (state_r == ST_IDLE);
  assign accept          = req_v_i & req_ready_and_o;

  // AXI-lite side, offset taken from the flat address
  assign awaddr_o  = hdr_r.addr.flat[`AXIL_ADDR_WIDTH-1:0];
  assign araddr_o  = hdr_r.addr.flat[`AXIL_ADDR_WIDTH-1:0];
  assign awprot_o  = 3'b000;
  assign arprot_o  = 3'b000;
  assign wdata_o   = wdata_r;
  assign wstrb_o   = wstrb_r;
  assign awvalid_o = (state_r == ST_ISSUE) & is_write & ~aw_done_r;
  assign wvalid_o  = (state_r == ST_ISSUE) & is_write & ~w_done_r;
  assign arvalid_o = (state_r == ST_ISSUE) & ~is_write;
  assign bready_o  = (state_r == ST_WAIT) & is_write;
  assign rready_o  = (state_r == ST_WAIT) & ~is_write;

  assign aw_fire = awvalid_o & awready_i;
  assign w_fire  = wvalid_o & wready_i;
  assign ar_fire = arvalid_o & arready_i;
  assign b_fire  = bvalid_i & bready_o;
  assign r_fire  = rvalid_i & rready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r   <= ST_IDLE;
      aw_done_r <= 1'b0;
      w_done_r  <= 1'b0;
    end
    else
    begin
      case (state_r)
        ST_IDLE:
        begin
          if (accept)
          begin
            state_r   <= ST_ISSUE;
            aw_done_r <= 1'b0;
            w_done_r  <= 1'b0;
          end
        end
        ST_ISSUE:
        begin
          // AW and W may complete in either order
          if (aw_fire)
            aw_done_r <= 1'b1;
          if (w_fire)
            w_done_r <= 1'b1;
          if (is_write && (aw_done_r || aw_fire) && (w_done_r || w_fire))
            state_r <= ST_WAIT;
          else if (ar_fire)
            state_r <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (b_fire || r_fire)
            state_r <= ST_RESP;
        end
        default:
        begin
          if (resp_ready_and_i)
            state_r <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      hdr_r   <= req_i.header;
      wdata_r <= req_i.data[`AXIL_DATA_WIDTH-1:0];
      wstrb_r <= strb;
    end
    // Addressed bytes moved down to lane 0
    if (r_fire)
      rdata_r <= rdata_i >> {hdr_lane, 3'b000};
  end

  // Read bytes replicated over the fill word
  always_comb
  begin
    resp_o.header = hdr_r;
    if (is_write)
      resp_o.data = '0;
    else
    begin
      case (hdr_r.size)
        SIZE_1:  resp_o.data = {(`FILL_WIDTH/8){rdata_r[7:0]}};
        SIZE_2:  resp_o.data = {(`FILL_WIDTH/16){rdata_r[15:0]}};
        default: resp_o.data = {(`FILL_WIDTH/32){rdata_r[31:0]}};
      endcase
    end
  end

  assign resp_v_o = (state_r == ST_RESP);

  assert property (@(posedge clk_i) disable iff (rst_i)
    accept |-> (req_i.header.size != SIZE_8))
    else $error("8-byte access on a 32-bit AXI-lite port");

  assert property (@(posedge clk_i) disable iff (rst_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else $error("AWVALID or AWADDR changed before AWREADY");

  assert property (@(posedge clk_i) disable iff (rst_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
    else $error("WVALID or W payload changed before WREADY");

  assert property (@(posedge clk_i) disable iff (rst_i)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else $error("ARVALID or ARADDR changed before ARREADY");

  // Error responses pass through as normal completions
  cover property (@(posedge clk_i) disable iff (rst_i)
    (b_fire && bresp_i != 2'b00) || (r_fire && rresp_i != 2'b00));

endmodule

`default_nettype wire

// File: mem_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module mem_axil_bridge
  import mem_bridge_pkg::*;
(
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_i,

  input  wire mem_msg_s                                      fwd_i,
  input  wire logic                                          fwd_v_i,
  output logic                                               fwd_ready_and_o,

  output mem_msg_s                                           rev_o,
  output logic                                               rev_v_o,
  input  wire logic                                          rev_ready_and_i,

  // AXI-lite masters, one slice per port
  output logic [`BRIDGE_PORTS-1:0][`AXIL_ADDR_WIDTH-1:0]     m_axil_awaddr_o,
  output logic [`BRIDGE_PORTS-1:0]                           m_axil_awvalid_o,
  input  wire logic [`BRIDGE_PORTS-1:0]                      m_axil_awready_i,
  output logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH-1:0]     m_axil_wdata_o,
  output logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH/8-1:0]   m_axil_wstrb_o,
  output logic [`BRIDGE_PORTS-1:0]                           m_axil_wvalid_o,
  input  wire logic [`BRIDGE_PORTS-1:0]                      m_axil_wready_i,
  input  wire logic [`BRIDGE_PORTS-1:0][1:0]                 m_axil_bresp_i,
  input  wire logic [`BRIDGE_PORTS-1:0]                      m_axil_bvalid_i,
  output logic [`BRIDGE_PORTS-1:0]                           m_axil_bready_o,
  output logic [`BRIDGE_PORTS-1:0][`AXIL_ADDR_WIDTH-1:0]     m_axil_araddr_o,
  output logic [`BRIDGE_PORTS-1:0]                           m_axil_arvalid_o,
  input  wire logic [`BRIDGE_PORTS-1:0]                      m_axil_arready_i,
  input  wire logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH-1:0] m_axil_rdata_i,
  input  wire logic [`BRIDGE_PORTS-1:0][1:0]                 m_axil_rresp_i,
  input  wire logic [`BRIDGE_PORTS-1:0]                      m_axil_rvalid_i,
  output logic [`BRIDGE_PORTS-1:0]                           m_axil_rready_o
);

  mem_msg_s                         port_msg;
  logic [`BRIDGE_PORTS-1:0]         port_v;
  logic [`BRIDGE_PORTS-1:0]         port_ready;
  logic                             issue_v;
  port_idx_t                        issue_port;
  mem_msg_s [`BRIDGE_PORTS-1:0]     resp_msg;
  logic [`BRIDGE_PORTS-1:0]         resp_v;
  logic [`BRIDGE_PORTS-1:0]         resp_ready;

  mem_req_dispatch dispatch_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fwd_i           (fwd_i),
    .fwd_v_i         (fwd_v_i),
    .fwd_ready_and_o (fwd_ready_and_o),
    .port_msg_o      (port_msg),
    .port_v_o        (port_v),
    .port_ready_i    (port_ready),
    .issue_v_o       (issue_v),
    .issue_port_o    (issue_port)
  );

  for (genvar p = 0; p < `BRIDGE_PORTS; p++)
  begin : g_port
    // Protection bits stay at zero and are not brought out
    axil_port_master port_master_i (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (port_msg),
      .req_v_i          (port_v[p]),
      .req_ready_and_o  (port_ready[p]),
      .resp_o           (resp_msg[p]),
      .resp_v_o         (resp_v[p]),
      .resp_ready_and_i (resp_ready[p]),
      .awaddr_o         (m_axil_awaddr_o[p]),
      .awprot_o         (),
      .awvalid_o        (m_axil_awvalid_o[p]),
      .awready_i        (m_axil_awready_i[p]),
      .wdata_o          (m_axil_wdata_o[p]),
      .wstrb_o          (m_axil_wstrb_o[p]),
      .wvalid_o         (m_axil_wvalid_o[p]),
      .wready_i         (m_axil_wready_i[p]),
      .bresp_i          (m_axil_bresp_i[p]),
      .bvalid_i         (m_axil_bvalid_i[p]),
      .bready_o         (m_axil_bready_o[p]),
      .araddr_o         (m_axil_araddr_o[p]),
      .arprot_o         (),
      .arvalid_o        (m_axil_arvalid_o[p]),
      .arready_i        (m_axil_arready_i[p]),
      .rdata_i          (m_axil_rdata_i[p]),
      .rresp_i          (m_axil_rresp_i[p]),
      .rvalid_i         (m_axil_rvalid_i[p]),
      .rready_o         (m_axil_rready_o[p])
    );
  end

  mem_resp_merge merge_i (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .issue_v_i         (issue_v),
    .issue_port_i      (issue_port),
    .port_resp_i       (resp_msg),
    .port_resp_v_i     (resp_v),
    .port_resp_ready_o (resp_ready),
    .rev_o             (rev_o),
    .rev_v_o           (rev_v_o),
    .rev_ready_and_i   (rev_ready_and_i)
  );

endmodule

`default_nettype wire

// File: mem_bridge_pkg.sv
`default_nettype none

`include "mem_bridge_settings.svh"

package mem_bridge_pkg;

  // Message type
  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_msg_e;

  // Access size, log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2,
    SIZE_8 = 2'd3
  } mem_size_e;

  // Region view of the physical address
  typedef struct packed {
    logic [`PADDR_WIDTH-`REGION_WIDTH-`AXIL_ADDR_WIDTH-1:0] unused;
    logic [`REGION_WIDTH-1:0]                               region;
    logic [`AXIL_ADDR_WIDTH-1:0]                            offset;
  } mem_addr_fields_s;

  // Same address word, flat or split into region and offset
  typedef union packed {
    logic [`PADDR_WIDTH-1:0] flat;
    mem_addr_fields_s        fields;
  } mem_addr_u;

  // Returned unchanged in the reverse message
  typedef struct packed {
    mem_msg_e  msg_type;
    mem_size_e size;
    mem_addr_u addr;
    logic [3:0] tag;
  } mem_header_s;

  // Header plus one fill word, used in both directions
  typedef struct packed {
    mem_header_s             header;
    logic [`FILL_WIDTH-1:0]  data;
  } mem_msg_s;

  typedef logic [$clog2(`BRIDGE_PORTS)-1:0] port_idx_t;

endpackage

`default_nettype wire

// File: mem_bridge_settings.svh
`ifndef MEM_BRIDGE_SETTINGS_SVH
`define MEM_BRIDGE_SETTINGS_SVH

// Number of AXI-lite master ports behind the bridge
`define BRIDGE_PORTS 2

// Region field selects the port, so it covers BRIDGE_PORTS
`define REGION_WIDTH 1

// AXI-lite address width, also the offset field of the physical address
`define AXIL_ADDR_WIDTH 12

// Physical address width on the memory network
`define PADDR_WIDTH 16

// Memory-side fill word
`define FILL_WIDTH 64

// AXI-lite data bus
`define AXIL_DATA_WIDTH 32

// Order queue depth
// one entry per port, since a port holds a single request at a time
`define ORDER_DEPTH 2

`endif

// File: mem_req_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module mem_req_dispatch
  import mem_bridge_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,

  // Forward messages from the memory network
  input  wire mem_msg_s                 fwd_i,
  input  wire logic                     fwd_v_i,
  output logic                          fwd_ready_and_o,

  // Toward the port masters
  output mem_msg_s                      port_msg_o,
  output logic [`BRIDGE_PORTS-1:0]      port_v_o,
  input  wire logic [`BRIDGE_PORTS-1:0] port_ready_i,

  // Issue event for the response merger
  output logic                          issue_v_o,
  output port_idx_t                     issue_port_o
);

  port_idx_t sel;

  // Region bits of the address pick the port
  assign sel = port_idx_t'(fwd_i.header.addr.fields.region);

  always_comb
  begin
    port_v_o      = '0;
    port_v_o[sel] = fwd_v_i;
  end

  // Every master sees the same message, only one sees valid
  assign port_msg_o      = fwd_i;
  assign fwd_ready_and_o = port_ready_i[sel];

  // Accepted transfer gets a slot in the order queue
  assign issue_v_o    = fwd_v_i & fwd_ready_and_o;
  assign issue_port_o = sel;

  // Address must map onto an existing port
  assert property (@(posedge clk_i) disable iff (rst_i)
    fwd_v_i |-> (fwd_i.header.addr.fields.region < `BRIDGE_PORTS))
    else $error("forward address region has no port");

  // Valid must hold until the selected port takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    fwd_v_i && !fwd_ready_and_o |=> fwd_v_i)
    else $error("forward valid dropped before ready");

endmodule

`default_nettype wire

// File: mem_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module mem_resp_merge
  import mem_bridge_pkg::*;
(
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,

  // Issue order from the dispatcher
  input  wire logic                                issue_v_i,
  input  wire port_idx_t                           issue_port_i,

  // Responses from the port masters
  input  wire mem_msg_s [`BRIDGE_PORTS-1:0]        port_resp_i,
  input  wire logic [`BRIDGE_PORTS-1:0]            port_resp_v_i,
  output logic [`BRIDGE_PORTS-1:0]                 port_resp_ready_o,

  // Reverse messages to the memory network
  output mem_msg_s                                 rev_o,
  output logic                                     rev_v_o,
  input  wire logic                                rev_ready_and_i
);

  localparam int PTR_WIDTH = (`ORDER_DEPTH > 1) ? $clog2(`ORDER_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(`ORDER_DEPTH + 1);

  port_idx_t              order_q [`ORDER_DEPTH];
  logic [PTR_WIDTH-1:0]   rd_ptr_r;
  logic [PTR_WIDTH-1:0]   wr_ptr_r;
  logic [CNT_WIDTH-1:0]   count_r;
  port_idx_t              head;
  logic                   empty;
  logic                   full;
  logic                   pop;

  assign head  = order_q[rd_ptr_r];
  assign empty = (count_r == '0);
  assign full  = (count_r == CNT_WIDTH'(`ORDER_DEPTH));

  // Only the oldest outstanding port may answer
  assign rev_o   = port_resp_i[head];
  assign rev_v_o = ~empty & port_resp_v_i[head];
  assign pop     = rev_v_o & rev_ready_and_i;

  always_comb
  begin
    port_resp_ready_o = '0;
    if (!empty)
      port_resp_ready_o[head] = rev_ready_and_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (issue_v_i)
        wr_ptr_r <= (wr_ptr_r == PTR_WIDTH'(`ORDER_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == PTR_WIDTH'(`ORDER_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      if (issue_v_i && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !issue_v_i)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_v_i)
      order_q[wr_ptr_r] <= issue_port_i;
  end

  // Each port holds one request, so the queue cannot overflow
  assert property (@(posedge clk_i) disable iff (rst_i)
    issue_v_i |-> !full)
    else $error("order queue push while full");

endmodule

`default_nettype wire

// File: tb_axil_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module tb_axil_mem_model
#(
  parameter int PORT_ID = 0
)
(
  input  wire logic                          clk_i,
  input  wire logic [`AXIL_ADDR_WIDTH-1:0]   awaddr_i,
  input  wire logic                          awvalid_i,
  output logic                               awready_o,
  input  wire logic [`AXIL_DATA_WIDTH-1:0]   wdata_i,
  input  wire logic [`AXIL_DATA_WIDTH/8-1:0] wstrb_i,
  input  wire logic                          wvalid_i,
  output logic                               wready_o,
  output logic [1:0]                         bresp_o,
  output logic                               bvalid_o,
  input  wire logic                          bready_i,
  input  wire logic [`AXIL_ADDR_WIDTH-1:0]   araddr_i,
  input  wire logic                          arvalid_i,
  output logic                               arready_o,
  output logic [`AXIL_DATA_WIDTH-1:0]        rdata_o,
  output logic [1:0]                         rresp_o,
  output logic                               rvalid_o,
  input  wire logic                          rready_i
);

  logic [`AXIL_DATA_WIDTH-1:0] mem [1024];
  integer                      seed;

  // 0 to 7 idle cycles, then land just after the edge
  task automatic wait_random();
    int d;
    d = $unsigned($random(seed)) % 8;
    repeat (d) @(posedge clk_i);
    #2;
  endtask

  task automatic serve_write();
    logic [9:0] idx;
    int         b;
    wait_random();
    awready_o = 1'b1;
    wready_o  = 1'b1;
    @(posedge clk_i);
    idx = awaddr_i[`AXIL_ADDR_WIDTH-1:2];
    // Only strobed byte lanes change
    for (b = 0; b < `AXIL_DATA_WIDTH/8; b++)
      if (wstrb_i[b])
        mem[idx][b*8 +: 8] = wdata_i[b*8 +: 8];
    #2;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    wait_random();
    bvalid_o = 1'b1;
    do
      @(posedge clk_i);
    while (!bready_i);
    #2;
    bvalid_o = 1'b0;
  endtask

  task automatic serve_read();
    logic [9:0] idx;
    wait_random();
    arready_o = 1'b1;
    @(posedge clk_i);
    idx = araddr_i[`AXIL_ADDR_WIDTH-1:2];
    #2;
    arready_o = 1'b0;
    wait_random();
    rdata_o  = mem[idx];
    rvalid_o = 1'b1;
    do
      @(posedge clk_i);
    while (!rready_i);
    #2;
    rvalid_o = 1'b0;
  endtask

  initial
  begin
    // Each port gets its own delay sequence
    seed      = 32'h32e0e4df + PORT_ID;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bresp_o   = 2'b00;
    bvalid_o  = 1'b0;
    arready_o = 1'b0;
    rdata_o   = '0;
    rresp_o   = 2'b00;
    rvalid_o  = 1'b0;
    for (int i = 0; i < 1024; i++)
      mem[i] = '0;
    forever
    begin
      @(posedge clk_i);
      if (awvalid_i && wvalid_i)
        serve_write();
      else if (arvalid_i)
        serve_read();
    end
  end

endmodule

`default_nettype wire

// File: tb_mem_axil_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_settings.svh"

module tb_mem_axil_bridge
  import mem_bridge_pkg::*;
();

  localparam int ROWS        = 16;
  localparam int CYCLE_LIMIT = ROWS * 40 + 200;

  // One request and the fill word expected back for it
  typedef struct packed {
    mem_msg_e                msg_type;
    mem_size_e               size;
    logic [`PADDR_WIDTH-1:0] addr;
    logic [3:0]              tag;
    logic [`FILL_WIDTH-1:0]  wdata;
    logic [`FILL_WIDTH-1:0]  exp_data;
  } stim_row_s;

  logic      clk;
  logic      rst;
  mem_msg_s  fwd;
  logic      fwd_v;
  logic      fwd_ready;
  mem_msg_s  rev;
  logic      rev_v;
  logic      rev_ready;
  int        cycle_count = 0;
  stim_row_s stim [ROWS];

  wire logic [`BRIDGE_PORTS-1:0][`AXIL_ADDR_WIDTH-1:0]   awaddr;
  wire logic [`BRIDGE_PORTS-1:0]                         awvalid;
  wire logic [`BRIDGE_PORTS-1:0]                         awready;
  wire logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH-1:0]   wdata;
  wire logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH/8-1:0] wstrb;
  wire logic [`BRIDGE_PORTS-1:0]                         wvalid;
  wire logic [`BRIDGE_PORTS-1:0]                         wready;
  wire logic [`BRIDGE_PORTS-1:0][1:0]                    bresp;
  wire logic [`BRIDGE_PORTS-1:0]                         bvalid;
  wire logic [`BRIDGE_PORTS-1:0]                         bready;
  wire logic [`BRIDGE_PORTS-1:0][`AXIL_ADDR_WIDTH-1:0]   araddr;
  wire logic [`BRIDGE_PORTS-1:0]                         arvalid;
  wire logic [`BRIDGE_PORTS-1:0]                         arready;
  wire logic [`BRIDGE_PORTS-1:0][`AXIL_DATA_WIDTH-1:0]   rdata;
  wire logic [`BRIDGE_PORTS-1:0][1:0]                    rresp;
  wire logic [`BRIDGE_PORTS-1:0]                         rvalid;
  wire logic [`BRIDGE_PORTS-1:0]                         rready;

  mem_axil_bridge mem_axil_bridge_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .fwd_i            (fwd),
    .fwd_v_i          (fwd_v),
    .fwd_ready_and_o  (fwd_ready),
    .rev_o            (rev),
    .rev_v_o          (rev_v),
    .rev_ready_and_i  (rev_ready),
    .m_axil_awaddr_o  (awaddr),
    .m_axil_awvalid_o (awvalid),
    .m_axil_awready_i (awready),
    .m_axil_wdata_o   (wdata),
    .m_axil_wstrb_o   (wstrb),
    .m_axil_wvalid_o  (wvalid),
    .m_axil_wready_i  (wready),
    .m_axil_bresp_i   (bresp),
    .m_axil_bvalid_i  (bvalid),
    .m_axil_bready_o  (bready),
    .m_axil_araddr_o  (araddr),
    .m_axil_arvalid_o (arvalid),
    .m_axil_arready_i (arready),
    .m_axil_rdata_i   (rdata),
    .m_axil_rresp_i   (rresp),
    .m_axil_rvalid_i  (rvalid),
    .m_axil_rready_o  (rready)
  );

  for (genvar p = 0; p < `BRIDGE_PORTS; p++)
  begin : g_mem
    tb_axil_mem_model #(.PORT_ID(p)) mem_model_i (
      .clk_i     (clk),
      .awaddr_i  (awaddr[p]),
      .awvalid_i (awvalid[p]),
      .awready_o (awready[p]),
      .wdata_i   (wdata[p]),
      .wstrb_i   (wstrb[p]),
      .wvalid_i  (wvalid[p]),
      .wready_o  (wready[p]),
      .bresp_o   (bresp[p]),
      .bvalid_o  (bvalid[p]),
      .bready_i  (bready[p]),
      .araddr_i  (araddr[p]),
      .arvalid_i (arvalid[p]),
      .arready_o (arready[p]),
      .rdata_o   (rdata[p]),
      .rresp_o   (rresp[p]),
      .rvalid_o  (rvalid[p]),
      .rready_i  (rready[p])
    );
  end

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Errors found");
      $fatal(1, "Timeout: the bridge did not finish all %0d rows in %0d cycles",
             ROWS, CYCLE_LIMIT);
    end
  end

  task automatic load_table();
    // Word at 0x010 and merged sub-word writes at 0x020
    stim[0]  = '{MEM_WR, SIZE_4, 16'h0010, 4'h1, {2{32'ha1b2c3d4}}, 64'h0};
    stim[1]  = '{MEM_RD, SIZE_4, 16'h0010, 4'h2, 64'h0, {2{32'ha1b2c3d4}}};
    stim[2]  = '{MEM_WR, SIZE_4, 16'h0020, 4'h3, {2{32'h11223344}}, 64'h0};
    stim[3]  = '{MEM_WR, SIZE_1, 16'h0021, 4'h4, {8{8'h55}}, 64'h0};
    stim[4]  = '{MEM_WR, SIZE_2, 16'h0022, 4'h5, {4{16'h6677}}, 64'h0};
    stim[5]  = '{MEM_RD, SIZE_4, 16'h0020, 4'h6, 64'h0, {2{32'h66775544}}};
    stim[6]  = '{MEM_RD, SIZE_1, 16'h0023, 4'h7, 64'h0, {8{8'h66}}};
    stim[7]  = '{MEM_RD, SIZE_2, 16'h0020, 4'h8, 64'h0, {4{16'h5544}}};
    stim[8]  = '{MEM_RD, SIZE_1, 16'h0011, 4'h9, 64'h0, {8{8'hc3}}};
    // Region 1 has its own memory behind port 1
    stim[9]  = '{MEM_WR, SIZE_4, 16'h1010, 4'ha, {2{32'hdeadbeef}}, 64'h0};
    stim[10] = '{MEM_RD, SIZE_4, 16'h0010, 4'hb, 64'h0, {2{32'ha1b2c3d4}}};
    stim[11] = '{MEM_RD, SIZE_4, 16'h1010, 4'hc, 64'h0, {2{32'hdeadbeef}}};
    stim[12] = '{MEM_RD, SIZE_4, 16'h1020, 4'hd, 64'h0, 64'h0};
    stim[13] = '{MEM_RD, SIZE_2, 16'h1012, 4'he, 64'h0, {4{16'hdead}}};
    stim[14] = '{MEM_RD, SIZE_1, 16'h0010, 4'hf, 64'h0, {8{8'hd4}}};
    stim[15] = '{MEM_RD, SIZE_2, 16'h1010, 4'h0, 64'h0, {4{16'hbeef}}};
  endtask

  function automatic mem_header_s row_header(stim_row_s r);
    mem_header_s h;
    h.msg_type  = r.msg_type;
    h.size      = r.size;
    h.addr.flat = r.addr;
    h.tag       = r.tag;
    return h;
  endfunction

  task automatic check_header(mem_header_s got, mem_header_s exp, int row);
    if (got !== exp)
    begin
      $display("ERROR %0t: row %0d header %h, expected %h", $time, row, got, exp);
      $display("Errors found");
      $fatal(1, "reverse header mismatch");
    end
  endtask

  task automatic check_data(logic [`FILL_WIDTH-1:0] got, logic [`FILL_WIDTH-1:0] exp,
                            int row);
    if (got !== exp)
    begin
      $display("ERROR %0t: row %0d fill data %h, expected %h", $time, row, got, exp);
      $display("Errors found");
      $fatal(1, "reverse fill data mismatch");
    end
  endtask

  task automatic drive_rows();
    for (int i = 0; i < ROWS; i++)
    begin
      fwd.header = row_header(stim[i]);
      fwd.data   = stim[i].wdata;
      fwd_v      = 1'b1;
      do
        @(posedge clk);
      while (!fwd_ready);
      #2;
    end
    fwd_v = 1'b0;
  endtask

  task automatic collect_rows();
    for (int i = 0; i < ROWS; i++)
    begin
      // Stall the reverse side now and then
      if (i % 5 == 3)
      begin
        rev_ready = 1'b0;
        repeat (6) @(posedge clk);
        #2;
      end
      rev_ready = 1'b1;
      do
        @(posedge clk);
      while (!rev_v);
      check_header(rev.header, row_header(stim[i]), i);
      check_data(rev.data, stim[i].exp_data, i);
      #2;
    end
    rev_ready = 1'b0;
  endtask

  initial
  begin
    rst       = 1'b1;
    fwd       = '0;
    fwd_v     = 1'b0;
    rev_ready = 1'b0;
    load_table();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    fork
      drive_rows();
      collect_rows();
    join
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mem_bridge_pkg.sv
mem_req_dispatch.sv
axil_port_master.sv
mem_resp_merge.sv
mem_axil_bridge.sv
tb_axil_mem_model.sv
tb_mem_axil_bridge.sv
